/* include/rom_table.svh */
// Contents of the read-only window
localparam logic [31:0] rom_words [8] = '{
  32'h0000_0001,
  32'h1234_5678,
  32'h89ab_cdef,
  32'hffff_0000,
  32'h0f0f_0f0f,
  32'ha5a5_5a5a,
  32'h7fff_ffff,
  32'h8000_0000
};

/* source/bus_proto_pkg.sv */
package bus_proto_pkg;

  localparam int data_w = 32;
  localparam int addr_w = 32;

  typedef enum logic {
    single_read  = 1'b0,
    single_write = 1'b1
  } trans_kind_t;

  typedef enum logic {
    ok  = 1'b0,
    err = 1'b1
  } ack_t;

  ////////////////////
  // Router handshake states
  ////////////////////
  localparam logic [1:0] st_idle     = 2'd0; // Ready for master
  localparam logic [1:0] st_request  = 2'd1; // Offering to slave
  localparam logic [1:0] st_response = 2'd2; // Waiting on slave
  localparam logic [1:0] st_reply    = 2'd3; // Offering to master

endpackage

/* source/bus_map_pkg.sv */
package bus_map_pkg;

  localparam int slave_count  = 4;
  localparam int window_words = 8;
  localparam int offset_w     = $clog2(window_words);
  localparam int sel_w        = $clog2(slave_count);
  localparam int high_w       = bus_proto_pkg::addr_w - sel_w - offset_w;

  // Register windows first, table in the last one
  localparam int reg_count = slave_count - 1;
  localparam int rom_sel   = slave_count - 1;

  // Response delay of each register window
  localparam int reg_latency [reg_count] = '{0, 2, 5};

  ////////////////////
  // Address word
  ////////////////////
  typedef union packed {
    logic [bus_proto_pkg::addr_w-1:0] raw;
    struct packed {
      logic [high_w-1:0]   high;   // Nonzero means unmapped
      logic [sel_w-1:0]    sel;    // Window
      logic [offset_w-1:0] offset; // Word in window
    } win;
  } bus_addr_u;

endpackage

/* source/bus_router.sv */
`timescale 1ns/1ps

module bus_router (
  input  logic                                                      ck,
  input  logic                                                      rst,
  // Master request
  output logic                                                      master_in_notify,
  input  logic                                                      master_in_sync,
  input  bus_proto_pkg::trans_kind_t                                master_in_trans,
  input  bus_map_pkg::bus_addr_u                                    master_in_addr,
  input  logic [bus_proto_pkg::data_w-1:0]                          master_in_data,
  // Master response
  output logic                                                      master_out_notify,
  input  logic                                                      master_out_sync,
  output bus_proto_pkg::ack_t                                       master_out_ack,
  output logic [bus_proto_pkg::data_w-1:0]                          master_out_data,
  // Slave request
  output logic [bus_map_pkg::slave_count-1:0]                       slave_req_notify,
  input  logic [bus_map_pkg::slave_count-1:0]                       slave_req_sync,
  output bus_proto_pkg::trans_kind_t                                slave_req_trans,
  output logic [bus_map_pkg::offset_w-1:0]                          slave_req_offset,
  output logic [bus_proto_pkg::data_w-1:0]                          slave_req_data,
  // Slave response
  output logic [bus_map_pkg::slave_count-1:0]                       slave_resp_notify,
  input  logic [bus_map_pkg::slave_count-1:0]                       slave_resp_sync,
  input  logic [bus_map_pkg::slave_count-1:0]                       slave_resp_ack,
  input  logic [bus_map_pkg::slave_count-1:0][bus_proto_pkg::data_w-1:0] slave_resp_data
);

  import bus_proto_pkg::*;
  import bus_map_pkg::*;

  logic [1:0]          state;
  logic [1:0]          state_nxt;
  logic [sel_w-1:0]    sel_q;
  trans_kind_t         trans_q;
  logic [offset_w-1:0] offset_q;
  logic [data_w-1:0]   wdata_q;
  ack_t                ack_q;
  logic [data_w-1:0]   rdata_q;
  logic                accept;
  logic                unmapped;
  logic                resp_done;

  assign accept    = master_in_notify && master_in_sync;
  assign unmapped  = |master_in_addr.win.high;
  assign resp_done = (state == st_response) && slave_resp_sync[sel_q];

  ////////////////////
  // FSM
  ////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (master_in_sync) begin
          state_nxt = unmapped ? st_reply : st_request; // Unmapped answers at once
        end
      end
      st_request: begin
        if (slave_req_sync[sel_q]) begin
          state_nxt = st_response;
        end
      end
      st_response: begin
        if (slave_resp_sync[sel_q]) begin
          state_nxt = st_reply;
        end
      end
      st_reply: begin
        if (master_out_sync) begin
          state_nxt = st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge ck or posedge rst) begin
    if (rst) begin
      state <= st_idle;
      sel_q <= '0;
    end else begin
      state <= state_nxt;
      if (accept) begin
        sel_q <= master_in_addr.win.sel;
      end
    end
  end

  ////////////////////
  // Transaction payload
  ////////////////////
  always_ff @(posedge ck) begin
    if (accept) begin
      trans_q  <= master_in_trans;
      offset_q <= master_in_addr.win.offset;
      wdata_q  <= (master_in_trans == single_write) ? master_in_data : '0;
      // Reply for an unmapped address; a slave overwrites it
      ack_q    <= ok;
      rdata_q  <= '0;
    end else if (resp_done) begin
      ack_q   <= ack_t'(slave_resp_ack[sel_q]);
      rdata_q <= (trans_q == single_read) ? slave_resp_data[sel_q] : '0;
    end
  end

  assign master_in_notify  = (state == st_idle);
  assign master_out_notify = (state == st_reply);
  assign master_out_ack    = ack_q;
  assign master_out_data   = rdata_q;

  assign slave_req_trans  = trans_q;
  assign slave_req_offset = offset_q;
  assign slave_req_data   = wdata_q;

  always_comb begin
    slave_req_notify  = '0;
    slave_resp_notify = '0;
    if (state == st_request) begin
      slave_req_notify[sel_q] = 1'b1;
    end
    if (state == st_response) begin
      slave_resp_notify[sel_q] = 1'b1;
    end
  end

  // Only one slave is ever addressed, over both links together
  a_one_slave: assert property (@(posedge ck) disable iff (rst)
    $onehot0({slave_req_notify, slave_resp_notify}));

  // A stalled reply holds until the master takes it
  a_reply_held: assert property (@(posedge ck) disable iff (rst)
    master_out_notify && !master_out_sync |=>
      master_out_notify && $stable(master_out_ack) && $stable(master_out_data));

endmodule

/* source/reg_slave.sv */
`timescale 1ns/1ps

module reg_slave #(
  parameter int latency = 0
) (
  input  logic                             ck,
  input  logic                             rst,
  input  logic                             req_notify,
  output logic                             req_sync,
  input  bus_proto_pkg::trans_kind_t       req_trans,
  input  logic [bus_map_pkg::offset_w-1:0] req_offset,
  input  logic [bus_proto_pkg::data_w-1:0] req_data,
  input  logic                             resp_notify,
  output logic                             resp_sync,
  output bus_proto_pkg::ack_t              resp_ack,
  output logic [bus_proto_pkg::data_w-1:0] resp_data
);

  import bus_proto_pkg::*;
  import bus_map_pkg::*;

  localparam int cnt_w = (latency > 0) ? $clog2(latency + 1) : 1;

  logic [data_w-1:0] mem [window_words];
  logic              busy;
  logic [cnt_w-1:0]  cnt;
  logic [data_w-1:0] rdata_q;

  assign req_sync  = req_notify && !busy; // Accept at once when free
  assign resp_sync = busy && (cnt == '0);
  assign resp_ack  = ok;
  assign resp_data = rdata_q;

  always_ff @(posedge ck or posedge rst) begin
    if (rst) begin
      busy <= 1'b0;
      cnt  <= '0;
      for (int i = 0; i < window_words; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (req_sync) begin
        busy <= 1'b1;
        cnt  <= cnt_w'(latency);
        if (req_trans == single_write) begin
          mem[req_offset] <= req_data;
        end
      end else if (resp_sync && resp_notify) begin
        busy <= 1'b0;
      end else if (busy && (cnt != '0)) begin
        cnt <= cnt - 1'b1; // Latency countdown
      end
    end
  end

  // Read word taken at accept, writes answer zero
  always_ff @(posedge ck) begin
    if (req_sync) begin
      rdata_q <= (req_trans == single_read) ? mem[req_offset] : '0;
    end
  end

  // Response appears exactly latency cycles after an accepted request
  a_resp_after_req: assert property (@(posedge ck) disable iff (rst)
    $rose(resp_sync) |-> $past(req_notify && req_sync, latency + 1));

endmodule

/* source/rom_slave.sv */
`timescale 1ns/1ps

module rom_slave (
  input  logic                             ck,
  input  logic                             rst,
  input  logic                             req_notify,
  output logic                             req_sync,
  input  bus_proto_pkg::trans_kind_t       req_trans,
  input  logic [bus_map_pkg::offset_w-1:0] req_offset,
  input  logic [bus_proto_pkg::data_w-1:0] req_data,
  input  logic                             resp_notify,
  output logic                             resp_sync,
  output bus_proto_pkg::ack_t              resp_ack,
  output logic [bus_proto_pkg::data_w-1:0] resp_data
);

  import bus_proto_pkg::*;

  `include "rom_table.svh"

  logic              busy;
  ack_t              ack_q;
  logic [data_w-1:0] rdata_q;

  assign req_sync  = req_notify && !busy;
  assign resp_sync = busy; // Answer on the next cycle
  assign resp_ack  = ack_q;
  assign resp_data = rdata_q;

  always_ff @(posedge ck or posedge rst) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (req_sync) begin
      busy <= 1'b1;
    end else if (resp_sync && resp_notify) begin
      busy <= 1'b0;
    end
  end

  // Writes are refused, write data is dropped
  always_ff @(posedge ck) begin
    if (req_sync) begin
      ack_q   <= (req_trans == single_write) ? err : ok;
      rdata_q <= (req_trans == single_read) ? rom_words[req_offset] : '0;
    end
  end

  // Never accept while the router waits on this window's response
  a_req_sync: assert property (@(posedge ck) disable iff (rst)
    req_sync |-> req_notify && !resp_notify);

endmodule

/* source/bus_subsystem.sv */
`timescale 1ns/1ps

module bus_subsystem (
  input  logic                             ck,
  input  logic                             rst,
  output logic                             master_in_notify,
  input  logic                             master_in_sync,
  input  bus_proto_pkg::trans_kind_t       master_in_trans,
  input  bus_map_pkg::bus_addr_u           master_in_addr,
  input  logic [bus_proto_pkg::data_w-1:0] master_in_data,
  output logic                             master_out_notify,
  input  logic                             master_out_sync,
  output bus_proto_pkg::ack_t              master_out_ack,
  output logic [bus_proto_pkg::data_w-1:0] master_out_data
);

  import bus_proto_pkg::*;
  import bus_map_pkg::*;

  logic [slave_count-1:0]             slave_req_notify;
  logic [slave_count-1:0]             slave_req_sync;
  trans_kind_t                        slave_req_trans;
  logic [offset_w-1:0]                slave_req_offset;
  logic [data_w-1:0]                  slave_req_data;
  logic [slave_count-1:0]             slave_resp_notify;
  logic [slave_count-1:0]             slave_resp_sync;
  logic [slave_count-1:0]             slave_resp_ack;
  logic [slave_count-1:0][data_w-1:0] slave_resp_data;

  bus_router router_i (
    .ck                (ck),
    .rst               (rst),
    .master_in_notify  (master_in_notify),
    .master_in_sync    (master_in_sync),
    .master_in_trans   (master_in_trans),
    .master_in_addr    (master_in_addr),
    .master_in_data    (master_in_data),
    .master_out_notify (master_out_notify),
    .master_out_sync   (master_out_sync),
    .master_out_ack    (master_out_ack),
    .master_out_data   (master_out_data),
    .slave_req_notify  (slave_req_notify),
    .slave_req_sync    (slave_req_sync),
    .slave_req_trans   (slave_req_trans),
    .slave_req_offset  (slave_req_offset),
    .slave_req_data    (slave_req_data),
    .slave_resp_notify (slave_resp_notify),
    .slave_resp_sync   (slave_resp_sync),
    .slave_resp_ack    (slave_resp_ack),
    .slave_resp_data   (slave_resp_data)
  );

  ////////////////////
  // Register windows 0 to 2
  ////////////////////
  for (genvar i = 0; i < reg_count; i++) begin : reg_win
    reg_slave #(
      .latency (reg_latency[i])
    ) reg_slave_i (
      .ck          (ck),
      .rst         (rst),
      .req_notify  (slave_req_notify[i]),
      .req_sync    (slave_req_sync[i]),
      .req_trans   (slave_req_trans),
      .req_offset  (slave_req_offset),
      .req_data    (slave_req_data),
      .resp_notify (slave_resp_notify[i]),
      .resp_sync   (slave_resp_sync[i]),
      .resp_ack    (slave_resp_ack[i]),
      .resp_data   (slave_resp_data[i])
    );
  end

  rom_slave rom_slave_i (
    .ck          (ck),
    .rst         (rst),
    .req_notify  (slave_req_notify[rom_sel]),
    .req_sync    (slave_req_sync[rom_sel]),
    .req_trans   (slave_req_trans),
    .req_offset  (slave_req_offset),
    .req_data    (slave_req_data),
    .resp_notify (slave_resp_notify[rom_sel]),
    .resp_sync   (slave_resp_sync[rom_sel]),
    .resp_ack    (slave_resp_ack[rom_sel]),
    .resp_data   (slave_resp_data[rom_sel])
  );

endmodule

/* test/tb_bus_subsystem.sv */
`timescale 1ns/1ps

module tb_bus_subsystem;

  import bus_proto_pkg::*;
  import bus_map_pkg::*;

  `include "rom_table.svh"

  localparam int wait_limit = 50;

  logic              ck;
  logic              rst;
  logic              master_in_notify;
  logic              master_in_sync;
  trans_kind_t       master_in_trans;
  bus_addr_u         master_in_addr;
  logic [data_w-1:0] master_in_data;
  logic              master_out_notify;
  logic              master_out_sync;
  ack_t              master_out_ack;
  logic [data_w-1:0] master_out_data;

  logic [data_w-1:0] shadow [reg_count*window_words]; // Windows 0 to 2
  string             test_name;
  ack_t              exp_ack;
  logic [data_w-1:0] exp_data;
  logic              accept;
  logic              mapped_accept;

  assign accept        = master_in_notify && master_in_sync;
  assign mapped_accept = accept && (master_in_addr.win.high == '0);

  bus_subsystem bus_subsystem_i (
    .ck                (ck),
    .rst               (rst),
    .master_in_notify  (master_in_notify),
    .master_in_sync    (master_in_sync),
    .master_in_trans   (master_in_trans),
    .master_in_addr    (master_in_addr),
    .master_in_data    (master_in_data),
    .master_out_notify (master_out_notify),
    .master_out_sync   (master_out_sync),
    .master_out_ack    (master_out_ack),
    .master_out_data   (master_out_data)
  );

  initial begin
    ck = 1'b0;
    forever #2 ck = ~ck;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  ////////////////////
  // Checks
  ////////////////////
  a_reply_value: assert property (@(posedge ck) disable iff (rst)
    master_out_notify && master_out_sync |->
      master_out_ack == exp_ack && master_out_data == exp_data)
    else fail_run($sformatf("error %s: expected ack %s data %h, actual ack %s data %h",
      test_name, exp_ack.name(), exp_data, master_out_ack.name(), master_out_data));

  a_unmapped_latency: assert property (@(posedge ck) disable iff (rst)
    accept && (master_in_addr.win.high != '0) |=> master_out_notify)
    else fail_run($sformatf("%s: unmapped reply did not come one cycle after the request",
      test_name));

  // Two quiet cycles before any mapped reply
  a_mapped_latency: assert property (@(posedge ck) disable iff (rst)
    $past(mapped_accept) || $past(mapped_accept, 2) |-> !master_out_notify)
    else fail_run($sformatf("%s: mapped reply came too early", test_name));

  a_back_pressure: assert property (@(posedge ck) disable iff (rst)
    master_out_notify && !master_out_sync |=>
      master_out_notify && !master_in_notify &&
      $stable(master_out_ack) && $stable(master_out_data))
    else fail_run($sformatf("%s: stalled reply changed or a new request was offered",
      test_name));

  a_reset_state: assert property (@(posedge ck)
    $fell(rst) |-> master_in_notify && !master_out_notify &&
      bus_subsystem_i.slave_req_notify == '0 && bus_subsystem_i.slave_resp_notify == '0)
    else fail_run("notify outputs are wrong right after reset");

  ////////////////////
  // Master
  ////////////////////
  task automatic run_trans(input string name, input trans_kind_t kind,
                           input bus_addr_u addr, input logic [data_w-1:0] data,
                           input int hold);
    int n;
    int idx;
    n = 0;
    while (!master_in_notify) begin
      if (n >= wait_limit) begin
        fail_run($sformatf("%s: router not ready for a request after %0d cycles",
          name, wait_limit));
      end
      @(posedge ck);
      #1;
      n++;
    end
    test_name = name;
    exp_ack   = ok;
    exp_data  = '0;
    idx       = addr.win.sel * window_words + addr.win.offset;
    if (addr.win.high != '0) begin
      exp_ack = ok; // No slave reached
    end else if (addr.win.sel == sel_w'(rom_sel)) begin
      if (kind == single_write) begin
        exp_ack = err;
      end else begin
        exp_data = rom_words[addr.win.offset];
      end
    end else if (kind == single_write) begin
      shadow[idx] = data;
    end else begin
      exp_data = shadow[idx];
    end
    master_in_sync  = 1'b1;
    master_in_trans = kind;
    master_in_addr  = addr;
    master_in_data  = data;
    @(posedge ck);
    #1;
    master_in_sync = 1'b0;
    n = 0;
    while (!master_out_notify) begin
      if (n >= wait_limit) begin
        fail_run($sformatf("%s: no reply within %0d cycles", name, wait_limit));
      end
      @(posedge ck);
      #1;
      n++;
    end
    repeat (hold) begin // Back-pressure
      @(posedge ck);
      #1;
    end
    master_out_sync = 1'b1;
    @(posedge ck);
    #1;
    master_out_sync = 1'b0;
  endtask

  initial begin
    bus_addr_u addr;
    void'($urandom(32'h79a68dac));
    rst             = 1'b1;
    master_in_sync  = 1'b0;
    master_in_trans = single_read;
    master_in_addr  = '0;
    master_in_data  = '0;
    master_out_sync = 1'b0;
    test_name       = "reset";
    exp_ack         = ok;
    exp_data        = '0;
    for (int i = 0; i < reg_count * window_words; i++) begin
      shadow[i] = '0;
    end
    repeat (3) @(posedge ck);
    #1;
    rst = 1'b0;

    // Register windows with latencies 0, 2 and 5
    for (int w = 0; w < reg_count; w++) begin
      addr = '0;
      addr.win.sel = sel_w'(w);
      addr.win.offset = offset_w'($urandom);
      run_trans($sformatf("reg_reset_read w%0d", w), single_read, addr, $urandom, 0);
      for (int off = 0; off < window_words; off++) begin
        addr.win.offset = offset_w'(off);
        run_trans($sformatf("reg_write w%0d", w), single_write, addr, $urandom,
          int'($urandom % 5));
      end
      for (int k = 0; k < 10; k++) begin
        addr.win.offset = offset_w'($urandom);
        run_trans($sformatf("reg_read w%0d", w), single_read, addr, $urandom,
          int'($urandom % 5));
      end
    end
    for (int k = 0; k < 20; k++) begin
      addr = '0;
      addr.win.sel = sel_w'($urandom % reg_count);
      addr.win.offset = offset_w'($urandom);
      run_trans("reg_mixed", trans_kind_t'($urandom % 2), addr, $urandom,
        int'($urandom % 4));
    end

    ////////////////////
    // Table and unmapped
    ////////////////////
    addr = '0;
    addr.win.sel = sel_w'(rom_sel);
    for (int off = 0; off < window_words; off++) begin
      addr.win.offset = offset_w'(off);
      run_trans("rom_read", single_read, addr, $urandom, int'($urandom % 3));
    end
    addr.win.offset = offset_w'($urandom);
    run_trans("rom_write", single_write, addr, $urandom, int'($urandom % 3));
    run_trans("rom_read_after_write", single_read, addr, $urandom, 1);
    for (int k = 0; k < 8; k++) begin
      addr.raw = $urandom;
      if (addr.win.high == '0) begin
        addr.win.high[high_w-1] = 1'b1;
      end
      run_trans("unmapped", trans_kind_t'($urandom % 2), addr, $urandom,
        int'($urandom % 5));
    end

    repeat (2) @(posedge ck);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* compile.f */
source/bus_proto_pkg.sv
source/bus_map_pkg.sv
+incdir+include
source/bus_router.sv
source/reg_slave.sv
source/rom_slave.sv
source/bus_subsystem.sv
test/tb_bus_subsystem.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_bus_subsystem -o sim_bin
	-./obj_dir/sim_bin > sim.log 2>&1
	cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
